/* src/dcache_pkg.sv */
package dcache_pkg;

    // cache geometry.
    localparam int num_ways   = 4;
    localparam int num_sets   = 128;
    localparam int line_bytes = 64;

    // address and data.
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // address fields: tag 31:13, index 12:6, offset 5:0.
    typedef logic [18:0] tag_t;
    typedef logic [6:0]  index_t;
    typedef logic [5:0]  offset_t;

    // way selection.
    typedef logic [1:0]          way_t;
    typedef logic [num_ways-1:0] way_vec_t;

    typedef logic [line_bytes*8-1:0] line_t;

endpackage

/* src/dcache_if.sv */
`timescale 1ns/1ns

// set lookup between controller, tag store and victim choice.
interface dcache_set_if;
    dcache_pkg::index_t   index;
    dcache_pkg::tag_t     tag;
    dcache_pkg::way_vec_t valid_vec;
    dcache_pkg::way_vec_t hit_vec;
    logic                 install;
    dcache_pkg::way_t     install_way;
    dcache_pkg::way_t     victim_way;

    modport ctrl (
        output index, tag, install, install_way,
        input  valid_vec, hit_vec, victim_way
    );

    modport tags (
        input  index, tag, install, install_way,
        output valid_vec, hit_vec
    );

    modport victim (
        input  index, valid_vec, install,
        output victim_way
    );
endinterface

// line data access between controller and data store.
interface dcache_data_if;
    dcache_pkg::index_t  index;
    dcache_pkg::way_t    way;
    dcache_pkg::offset_t offset;
    dcache_pkg::word_t   rd_word;
    logic                wr_en;
    logic                store_size; // 1: byte, 0: halfword.
    dcache_pkg::word_t   wdata;
    logic                clear;

    modport ctrl (
        output index, way, offset, wr_en, store_size, wdata, clear,
        input  rd_word
    );

    modport store (
        input  index, way, offset, wr_en, store_size, wdata, clear,
        output rd_word
    );
endinterface

/* src/tag_store.sv */
`timescale 1ns/1ns

module tag_store (
    input logic         clk,
    input logic         rstn,
    dcache_set_if.tags  set
);

    // valid bits per set, one per way.
    dcache_pkg::way_vec_t valid_q [dcache_pkg::num_sets];
    dcache_pkg::tag_t     tag_q   [dcache_pkg::num_sets][dcache_pkg::num_ways];

    // parallel compare of all ways at the index.
    always_comb begin
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            set.valid_vec[w] = valid_q[set.index][w];
            set.hit_vec[w]   = valid_q[set.index][w] &&
                               (tag_q[set.index][w] == set.tag);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < dcache_pkg::num_sets; s++) begin
                valid_q[s] <= '0;
            end
        end else if (set.install) begin
            valid_q[set.index][set.install_way] <= 1'b1;
        end
    end

    // tags need no reset, valid gates them.
    always_ff @(posedge clk) begin
        if (set.install) begin
            tag_q[set.index][set.install_way] <= set.tag;
        end
    end

    // a tag lives in one way only.
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (!rstn)
        $onehot0(set.hit_vec)
    ) else $error("tag_store: tag present in more than one way");

endmodule

/* src/data_store.sv */
`timescale 1ns/1ns

module data_store (
    input logic           clk,
    input logic           rstn,
    dcache_data_if.store  dat
);

    dcache_pkg::line_t line_q [dcache_pkg::num_sets][dcache_pkg::num_ways];

    dcache_pkg::line_t cur_line;
    dcache_pkg::line_t new_line;

    assign cur_line = line_q[dat.index][dat.way];

    // aligned word read, bits 1:0 ignored.
    assign dat.rd_word = cur_line[{dat.offset[5:2], 5'b0} +: 32];

    // clear first on allocation, then merge the store.
    always_comb begin
        new_line = dat.clear ? '0 : cur_line;
        if (dat.store_size) begin
            new_line[{dat.offset, 3'b0} +: 8] = dat.wdata[7:0];
        end else begin
            // halfword aligned on offset bit 0.
            new_line[{dat.offset[5:1], 4'b0} +: 16] = dat.wdata[15:0];
        end
    end

    // no writes while held in reset.
    always_ff @(posedge clk) begin
        if (rstn && dat.wr_en) begin
            line_q[dat.index][dat.way] <= new_line;
        end
    end

endmodule

/* src/victim_select.sv */
`timescale 1ns/1ns

module victim_select (
    input logic           clk,
    input logic           rstn,
    dcache_set_if.victim  set
);

    // round-robin pointer per set.
    dcache_pkg::way_t rr_q [dcache_pkg::num_sets];

    logic             set_full;
    dcache_pkg::way_t free_way;

    assign set_full = &set.valid_vec;

    // lowest invalid way wins.
    always_comb begin
        free_way = '0;
        for (int w = dcache_pkg::num_ways - 1; w >= 0; w--) begin
            if (!set.valid_vec[w]) begin
                free_way = dcache_pkg::way_t'(w);
            end
        end
    end

    assign set.victim_way = set_full ? rr_q[set.index] : free_way;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < dcache_pkg::num_sets; s++) begin
                rr_q[s] <= '0;
            end
        end else if (set.install && set_full) begin
            rr_q[set.index] <= rr_q[set.index] + 2'd1; // wraps after way 3.
        end
    end

endmodule

/* src/dcache_ctrl.sv */
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic               clk,
    input  logic               rstn,
    input  dcache_pkg::addr_t  addr,
    input  dcache_pkg::word_t  wdata,
    input  logic               mem_read,
    input  logic               mem_write,
    input  logic               store_size,
    input  logic               from_lsq,
    output dcache_pkg::word_t  lw_data,
    output logic               cache_miss,
    dcache_set_if.ctrl         set,
    dcache_data_if.ctrl        dat
);

    dcache_pkg::tag_t    req_tag;
    dcache_pkg::index_t  req_index;
    dcache_pkg::offset_t req_offset;

    logic             hit;
    dcache_pkg::way_t hit_way;
    logic             do_read;
    logic             do_write;

    assign req_tag    = addr[31:13];
    assign req_index  = addr[12:6];
    assign req_offset = addr[5:0];

    assign do_read  = mem_read;
    assign do_write = mem_write && !mem_read; // read wins.

    assign hit = |set.hit_vec;

    // one-hot hit to way number.
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            if (set.hit_vec[w]) begin
                hit_way = dcache_pkg::way_t'(w);
            end
        end
    end

    assign set.index       = req_index;
    assign set.tag         = req_tag;
    assign set.install     = do_write && !hit;
    assign set.install_way = set.victim_way;

    // write miss goes to the victim, cleared.
    assign dat.index      = req_index;
    assign dat.offset     = req_offset;
    assign dat.way        = hit ? hit_way : set.victim_way;
    assign dat.wr_en      = do_write;
    assign dat.clear      = do_write && !hit;
    assign dat.store_size = store_size;
    assign dat.wdata      = wdata;

    // response register, held on idle cycles.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lw_data    <= '0;
            cache_miss <= 1'b0;
        end else if (do_read || do_write) begin
            if (from_lsq) begin
                lw_data    <= '0; // served by the LSQ.
                cache_miss <= 1'b0;
            end else if (do_read) begin
                lw_data    <= hit ? dat.rd_word : '0;
                cache_miss <= !hit;
            end else begin
                lw_data    <= '0;
                cache_miss <= !hit;
            end
        end
    end

    a_no_install_on_hit: assert property (
        @(posedge clk) disable iff (!rstn)
        !(set.install && |set.hit_vec)
    ) else $error("dcache_ctrl: install issued on a hit");

    a_miss_zero_data: assert property (
        @(posedge clk) disable iff (!rstn)
        cache_miss |-> (lw_data == '0)
    ) else $error("dcache_ctrl: nonzero data reported with a miss");

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ns

module dcache_top (
    input  logic               clk,
    input  logic               rstn,
    input  dcache_pkg::addr_t  pc,      // trace only.
    input  dcache_pkg::addr_t  addr,
    input  dcache_pkg::word_t  wdata,
    input  logic               mem_read,
    input  logic               mem_write,
    input  logic               store_size,
    input  logic               from_lsq,
    output dcache_pkg::word_t  lw_data,
    output logic               cache_miss
);

    dcache_set_if  set_bus ();
    dcache_data_if dat_bus ();

    dcache_ctrl u_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .addr       (addr),
        .wdata      (wdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .store_size (store_size),
        .from_lsq   (from_lsq),
        .lw_data    (lw_data),
        .cache_miss (cache_miss),
        .set        (set_bus.ctrl),
        .dat        (dat_bus.ctrl)
    );

    tag_store u_tags (
        .clk  (clk),
        .rstn (rstn),
        .set  (set_bus.tags)
    );

    data_store u_data (
        .clk  (clk),
        .rstn (rstn),
        .dat  (dat_bus.store)
    );

    victim_select u_victim (
        .clk  (clk),
        .rstn (rstn),
        .set  (set_bus.victim)
    );

endmodule

/* bench/dcache_model.svh */
`ifndef DCACHE_MODEL_SVH
`define DCACHE_MODEL_SVH

// model state per set and way, lines kept as bytes.
bit        m_valid [128][4];
bit [18:0] m_tag   [128][4];
bit [7:0]  m_byte  [128][4][64];
int        m_rr    [128];

function automatic void model_reset();
    for (int s = 0; s < 128; s++) begin
        m_rr[s] = 0;
        for (int w = 0; w < 4; w++) begin
            m_valid[s][w] = 1'b0;
        end
    end
endfunction

// expected response for one request; also updates the model.
function automatic void expect_response(
    input  logic [31:0] a,
    input  logic [31:0] wd,
    input  logic        rd,
    input  logic        wr,
    input  logic        byte_op,
    input  logic        lsq,
    output logic [31:0] exp_word,
    output logic        exp_miss
);
    int s;
    int way;
    int base;
    s = int'(a[12:6]);
    way = -1;
    for (int w = 0; w < 4; w++) begin
        if (m_valid[s][w] && m_tag[s][w] == a[31:13]) begin
            way = w;
        end
    end
    exp_word = '0;
    exp_miss = (way < 0);
    if (rd) begin
        base = int'(a[5:2]) * 4;
        if (way >= 0) begin
            exp_word = {m_byte[s][way][base+3], m_byte[s][way][base+2],
                        m_byte[s][way][base+1], m_byte[s][way][base]};
        end
    end else if (wr) begin
        if (way < 0) begin
            for (int w = 3; w >= 0; w--) begin
                if (!m_valid[s][w]) way = w; // lowest free way.
            end
            if (way < 0) begin
                way = m_rr[s];
                m_rr[s] = (m_rr[s] + 1) % 4;
            end
            for (int b = 0; b < 64; b++) begin
                m_byte[s][way][b] = 8'h00;
            end
            m_valid[s][way] = 1'b1;
            m_tag[s][way] = a[31:13];
        end
        if (byte_op) begin
            m_byte[s][way][int'(a[5:0])] = wd[7:0];
        end else begin
            base = int'(a[5:1]) * 2;
            m_byte[s][way][base] = wd[7:0];
            m_byte[s][way][base+1] = wd[15:8];
        end
    end
    if (lsq) begin
        exp_word = '0;
        exp_miss = 1'b0;
    end
endfunction

`endif

/* bench/tb_dcache.sv */
`timescale 1ns/1ns

module tb_dcache;

    `include "dcache_model.svh"

    localparam int          reset_cycles = 4;
    localparam int          num_random   = 400;
    localparam int          wait_limit   = 50;
    localparam logic [31:0] seed         = 32'h5d36_aed5;

    logic        clk;
    logic        rstn;
    logic [31:0] pc;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        mem_read;
    logic        mem_write;
    logic        store_size;
    logic        from_lsq;
    logic [31:0] lw_data;
    logic        cache_miss;

    logic [31:0] exp_data;
    logic        exp_miss;
    logic [31:0] exp_addr;
    logic        pending;
    int          errors;
    int          timeouts;
    int          issued;
    int          checked;

    dcache_top dut0 (
        .clk        (clk),
        .rstn       (rstn),
        .pc         (pc),
        .addr       (addr),
        .wdata      (wdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .store_size (store_size),
        .from_lsq   (from_lsq),
        .lw_data    (lw_data),
        .cache_miss (cache_miss)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2 rstn = 1'b1;
    end

    // outputs checked mid-cycle, then the request now on the inputs is modeled.
    always @(negedge clk) begin
        assert (lw_data === exp_data && cache_miss === exp_miss) else begin
            errors++;
            $display("mismatch at %0t: addr %h expected data %h miss %b, got data %h miss %b",
                     $time, exp_addr, exp_data, exp_miss, lw_data, cache_miss);
        end
        if (pending) checked++;
        pending = rstn && (mem_read || mem_write);
        if (pending) begin
            exp_addr = addr;
            expect_response(addr, wdata, mem_read, mem_write, store_size, from_lsq,
                            exp_data, exp_miss);
        end
    end

    function automatic logic [31:0] make_addr(input int t, input int s, input int o);
        return {t[18:0], s[6:0], o[5:0]};
    endfunction

    // one cycle of stimulus, applied just after the edge.
    task automatic drive(input logic rd, input logic wr, input logic [31:0] a,
                         input logic [31:0] d, input logic sz, input logic lsq);
        @(posedge clk);
        #2;
        mem_read = rd;
        mem_write = wr;
        addr = a;
        wdata = d;
        store_size = sz;
        from_lsq = lsq;
        pc = pc + 32'd4;
        if (rd || wr) issued++;
    endtask

    task automatic wait_reset_release(output bit ok);
        int n;
        n = 0;
        while (rstn !== 1'b1 && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        ok = (rstn === 1'b1);
        if (!ok) $display("timeout: reset was not released within %0d cycles", wait_limit);
    endtask

    task automatic wait_checks_done(output bit ok);
        int n;
        n = 0;
        while (checked < issued && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        ok = (checked >= issued);
        if (!ok) $display("timeout: only %0d of %0d responses were checked", checked, issued);
    endtask

    initial begin
        bit ok;
        int r;
        {pc, addr, wdata} = '0;
        {mem_read, mem_write, store_size, from_lsq} = '0;
        {exp_data, exp_addr} = '0;
        exp_miss = 1'b0;
        pending = 1'b0;
        {errors, timeouts, issued, checked} = '0;
        model_reset();
        void'($urandom(seed));
        wait_reset_release(ok);
        if (ok) begin
            drive(0, 0, '0, '0, 0, 0);
            drive(1, 0, make_addr(26, 3, 8), '0, 0, 0); // cold miss.
            drive(0, 1, make_addr(34, 5, 9), 32'h0000_00a5, 1, 0);
            drive(0, 1, make_addr(34, 5, 14), 32'h0000_c3b2, 0, 0);
            for (int o = 0; o < 64; o += 4) begin
                drive(1, 0, make_addr(34, 5, o), '0, 0, 0);
            end
            for (int t = 64; t < 69; t++) begin
                drive(0, 1, make_addr(t, 9, 0), t, 1, 0); // fifth evicts way 0.
            end
            for (int t = 64; t < 69; t++) begin
                drive(1, 0, make_addr(t, 9, 0), '0, 0, 0);
            end
            drive(1, 0, make_addr(65, 9, 0), '0, 0, 1);
            drive(0, 1, make_addr(90, 11, 3), 32'h0000_005c, 1, 1);
            drive(1, 0, make_addr(90, 11, 0), '0, 0, 0);
            for (int i = 0; i < num_random; i++) begin
                r = int'($urandom_range(0, 9));
                drive(r < 4 || r == 8, (r >= 4 && r < 8) || r == 8,
                      make_addr(768 + int'($urandom_range(0, 5)), int'($urandom_range(0, 2)),
                                int'($urandom_range(0, 63))),
                      $urandom(), $urandom_range(0, 1) != 0, $urandom_range(0, 15) == 0);
            end
            drive(0, 0, '0, '0, 0, 0);
            wait_checks_done(ok);
        end
        if (!ok) timeouts++;
        $display("%0d requests checked, %0d mismatches, %0d timeouts",
                 checked, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* src.f */
src/dcache_pkg.sv
src/dcache_if.sv
src/tag_store.sv
src/data_store.sv
src/victim_select.sv
src/dcache_ctrl.sv
src/dcache_top.sv
+incdir+bench
bench/tb_dcache.sv

/* Makefile */
# Verilator build and run for the data cache testbench.

VERILATOR ?= verilator
TOP       ?= tb_dcache
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Done: errors found

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard bench/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
